// File: piarb_buf.f
source/piarb_pkg.sv
source/ram_1r1w.sv
source/piarb_linked_list.sv
source/piarb_queue_ctrl.sv
source/piarb_cfg_regs.sv
source/piarb_top.sv
test/tb_clkgen.sv
test/piarb_assert.sv
test/tb_piarb.sv

// File: Makefile
# Verilator flow for the piarb_buf queue core

TOOL       = verilator
TOP        = tb_piarb
FLIST      = piarb_buf.f
FLAGS      = --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/100ps
OBJDIR     = obj_dir
LOG        = sim.log
PASS_MSG   = PASS: all tests

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJDIR)

sim: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: test/tb_piarb.sv
`timescale 1ns/100ps

module tb_piarb;
	import piarb_pkg::*;

	localparam int buf_nbits = BUF_NBITS;
	// Handshakes and register accesses of all tests, rounded up
	localparam int n_ops = 140;
	localparam int timeout_cycles = n_ops * 20 + 200;
	localparam int lfsr_seed = 66016;

	logic clk;
	logic rst_n;
	logic enq_req;
	buf_ptr_t enq_ptr;
	logic enq_ack;
	logic deq_req;
	logic deq_ack;
	buf_ptr_t deq_ptr;
	reg_bus_t reg_bus;
	logic [15:0] reg_rdata;

	buf_ptr_t model_q[$]; // Reference queue, oldest first
	logic [15:0] lfsr;
	string cur_test = "reset";
	int errors = 0;
	int test_errs = 0; // Errors seen before the current test
	int n_tests = 0;
	int n_link = 0; // Enqueues into a non-empty queue
	int n_deq = 0;
	int cycles = 0;
	logic deq_ack_prev = 1'b0;

	tb_clkgen #(.half_period(20), .reset_cycles(10)) u_clkgen (.clk(clk), .rst_n(rst_n));

	piarb_top #(
		.buf_nbits(buf_nbits)
	) DUT (
		.clk(clk),
		.rst_n(rst_n),
		.enq_req(enq_req),
		.enq_ptr(enq_ptr),
		.enq_ack(enq_ack),
		.deq_req(deq_req),
		.deq_ack(deq_ack),
		.deq_ptr(deq_ptr),
		.reg_bus(reg_bus),
		.reg_rdata(reg_rdata)
	);

	// ====================
	// LFSR and model
	// ====================
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // Taps 16 14 13 11
	endfunction

	function automatic logic rand_bit();
		lfsr = lfsr_next(lfsr);
		return lfsr[0];
	endfunction

	function automatic buf_ptr_t rand_ptr();
		buf_ptr_t p;
		p = '0;
		for (int i = 0; i < buf_nbits; i++) begin
			p = {p[buf_nbits-2:0], rand_bit()}; // One step per bit
		end
		return p;
	endfunction

	function automatic bit in_model(input buf_ptr_t p);
		foreach (model_q[i]) begin
			if (model_q[i] == p) return 1'b1;
		end
		return 1'b0;
	endfunction

	// Expected deq_ptr is the oldest pointer
	function automatic buf_ptr_t expected_deq();
		return model_q.pop_front();
	endfunction

	task automatic pick_ptr(output buf_ptr_t p);
		do begin
			p = rand_ptr();
		end while (in_model(p)); // Never a pointer still queued
	endtask

	// ====================
	// Checks
	// ====================
	task automatic report_error(input string msg);
		errors++;
		$display("error in %s: %s", cur_test, msg);
	endtask

	task automatic check_ptr(input string what, input buf_ptr_t exp, input buf_ptr_t act);
		if (act !== exp) begin
			errors++;
			$display("mismatch %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_depth(input string what, input depth_t exp, input depth_t act);
		if (act !== exp) begin
			errors++;
			$display("mismatch %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
		end
	endtask

	task automatic check_reg(input string what, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			errors++;
			$display("mismatch %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
		end
	endtask

	// Every rising deq_ack is compared with the model
	always @(negedge clk) begin
		if (deq_ack === 1'b1 && deq_ack_prev !== 1'b1) begin
			if (model_q.size() == 0) begin
				report_error("dequeue acknowledged while the model queue is empty");
			end else begin
				check_ptr("deq_ptr", expected_deq(), deq_ptr);
			end
			n_deq++;
		end
		deq_ack_prev = deq_ack;
	end

	// Watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == timeout_cycles) begin
			$display("timeout: %s did not finish within %0d cycles", cur_test, timeout_cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// ====================
	// Bus tasks
	// ====================
	task automatic start_enq(input buf_ptr_t p);
		@(posedge clk);
		enq_req <= 1'b1;
		enq_ptr <= p; // Held until ack
	endtask

	task automatic wait_enq_ack();
		do @(negedge clk); while (enq_ack !== 1'b1);
	endtask

	task automatic end_enq(input buf_ptr_t p);
		if (model_q.size() > 0) n_link++; // Linked behind a tail
		model_q.push_back(p);
		@(posedge clk);
		enq_req <= 1'b0;
		do @(negedge clk); while (enq_ack !== 1'b0);
	endtask

	task automatic enqueue(input buf_ptr_t p);
		start_enq(p);
		wait_enq_ack();
		end_enq(p);
	endtask

	task automatic start_deq();
		@(posedge clk);
		deq_req <= 1'b1;
	endtask

	task automatic wait_deq_ack();
		do @(negedge clk); while (deq_ack !== 1'b1);
	endtask

	task automatic end_deq();
		@(posedge clk);
		deq_req <= 1'b0;
		do @(negedge clk); while (deq_ack !== 1'b0);
	endtask

	task automatic dequeue();
		start_deq();
		wait_deq_ack();
		end_deq();
	endtask

	// Pending request must see no ack for a while
	task automatic expect_held(input bit is_enq, input int n);
		repeat (n) begin
			@(negedge clk);
			if (is_enq && enq_ack === 1'b1) report_error("enqueue acknowledged too early");
			if (!is_enq && deq_ack === 1'b1) report_error("dequeue acknowledged too early");
		end
	endtask

	task automatic reg_write(input reg_addr_t a, input logic [15:0] d);
		@(posedge clk);
		reg_bus <= '{wr: 1'b1, rd: 1'b0, addr: a, wdata: d};
		@(posedge clk);
		reg_bus <= '0;
	endtask

	task automatic reg_read(input reg_addr_t a, output logic [15:0] d);
		@(posedge clk);
		reg_bus <= '{wr: 1'b0, rd: 1'b1, addr: a, wdata: 16'd0};
		@(posedge clk);
		reg_bus <= '0;
		@(negedge clk);
		d = reg_rdata; // Registered one cycle after the read
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_errs = errors;
	endtask

	task automatic end_test();
		n_tests++;
		$display("test %s finished with %0d errors", cur_test, errors - test_errs);
	endtask

	// ====================
	// Test sequence
	// ====================
	initial begin
		buf_ptr_t p;
		logic [15:0] rd;
		enq_req <= 1'b0;
		enq_ptr <= '0;
		deq_req <= 1'b0;
		reg_bus <= '0;
		lfsr = 16'(lfsr_seed); // Low 16 bits of the seed
		wait (rst_n === 1'b1);

		begin_test("enable");
		reg_read(reg_limit, rd);
		check_reg("reset limit and depth", 16'(1 << buf_nbits), rd);
		pick_ptr(p);
		start_enq(p);
		expect_held(1'b1, 30); // Disabled after reset
		reg_write(reg_ctrl, 16'd1);
		wait_enq_ack();
		end_enq(p);
		dequeue();
		end_test();

		begin_test("order");
		repeat (16) begin
			pick_ptr(p);
			enqueue(p);
		end
		repeat (16) dequeue();
		end_test();

		begin_test("limit");
		reg_write(reg_limit, 16'd4);
		repeat (4) begin
			pick_ptr(p);
			enqueue(p);
		end
		reg_read(reg_limit, rd);
		check_depth("depth at limit", depth_t'(model_q.size()), depth_t'(rd[15:8]));
		check_reg("limit", 16'd4, {8'd0, rd[7:0]});
		pick_ptr(p);
		start_enq(p);
		expect_held(1'b1, 30); // Back-pressure
		dequeue(); // Frees one slot
		wait_enq_ack();
		end_enq(p);
		reg_read(reg_limit, rd);
		check_depth("depth after refill", depth_t'(model_q.size()), depth_t'(rd[15:8]));
		while (model_q.size() > 0) dequeue();
		reg_write(reg_limit, 16'(1 << buf_nbits));
		end_test();

		begin_test("empty_deq");
		pick_ptr(p);
		start_deq();
		expect_held(1'b0, 30);
		enqueue(p); // Serves the waiting dequeue
		wait_deq_ack();
		end_deq();
		end_test();

		begin_test("interleave");
		repeat (40) begin
			if (model_q.size() == 0 || rand_bit()) begin
				pick_ptr(p);
				enqueue(p);
			end else begin
				dequeue();
			end
		end
		while (model_q.size() > 0) dequeue();
		end_test();

		begin_test("counters");
		reg_read(reg_wr_cnt, rd);
		check_reg("write count", 16'(n_link), rd);
		reg_read(reg_rd_cnt, rd);
		check_reg("read count", 16'(n_deq), rd);
		end_test();

		$display("tests run: %0d, errors: %0d", n_tests, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: test/piarb_assert.sv
`timescale 1ns/100ps

module piarb_assert (
	input logic clk,
	input logic rst_n,
	input logic enq_req,
	input logic enq_ack,
	input logic deq_req,
	input logic deq_ack,
	input piarb_pkg::depth_t depth,
	input piarb_pkg::cfg_t cfg
);

	// ====================
	// Handshake rules
	// ====================
	// Ack may only drop once its req is gone
	a_enq_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(enq_ack && enq_req) |=> enq_ack)
		else $error("enq_ack dropped while enq_req was still high");

	a_deq_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(deq_ack && deq_req) |=> deq_ack)
		else $error("deq_ack dropped while deq_req was still high");

	// ====================
	// Occupancy
	// ====================
	a_depth_limit: assert property (@(posedge clk) disable iff (!rst_n)
		depth <= cfg.limit)
		else $error("queue depth %0d above limit %0d", depth, cfg.limit);

	// Nothing to hand out from an empty chain
	a_deq_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(deq_ack) |-> (depth != '0))
		else $error("deq_ack rose with an empty queue");

endmodule

bind piarb_queue_ctrl piarb_assert u_assert (
	.clk(clk),
	.rst_n(rst_n),
	.enq_req(enq_req),
	.enq_ack(enq_ack),
	.deq_req(deq_req),
	.deq_ack(deq_ack),
	.depth(depth),
	.cfg(cfg)
);

// File: test/tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen #(
	parameter int half_period = 20, // 40 ns clock
	parameter int reset_cycles = 10
) (
	output logic clk,
	output logic rst_n
);

	initial clk = 1'b0;
	always #half_period clk = ~clk;

	// Reset low for the first cycles, released on a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// File: source/piarb_top.sv
`timescale 1ns/100ps

module piarb_top #(
	parameter int buf_nbits = piarb_pkg::BUF_NBITS
) (
	input logic clk,
	input logic rst_n,
	// Enqueue port
	input logic enq_req,
	input piarb_pkg::buf_ptr_t enq_ptr,
	output logic enq_ack,
	// Dequeue port
	input logic deq_req,
	output logic deq_ack,
	output piarb_pkg::buf_ptr_t deq_ptr,
	// Register port
	input piarb_pkg::reg_bus_t reg_bus,
	output logic [15:0] reg_rdata
);
	import piarb_pkg::*;

	ll_req_t ll_req; // Controller to linked list
	ll_rsp_t ll_rsp; // Linked list back, counters tap it
	cfg_t cfg;
	depth_t depth; // Status for software

	// ====================
	// Queue controller
	// ====================
	piarb_queue_ctrl #(
		.buf_nbits(buf_nbits)
	) u_queue_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.enq_req(enq_req),
		.enq_ptr(enq_ptr),
		.enq_ack(enq_ack),
		.deq_req(deq_req),
		.deq_ack(deq_ack),
		.deq_ptr(deq_ptr),
		.cfg(cfg),
		.ll_req(ll_req),
		.ll_rsp(ll_rsp),
		.depth(depth)
	);

	piarb_linked_list #(
		.buf_nbits(buf_nbits)
	) u_linked_list (
		.clk(clk),
		.rst_n(rst_n),
		.ll_req(ll_req),
		.ll_rsp(ll_rsp)
	);

	// Registers beside the controller
	piarb_cfg_regs #(
		.buf_nbits(buf_nbits)
	) u_cfg_regs (
		.clk(clk),
		.rst_n(rst_n),
		.reg_bus(reg_bus),
		.reg_rdata(reg_rdata),
		.depth(depth),
		.inc_rd(ll_rsp.inc_rd),
		.inc_wr(ll_rsp.inc_wr),
		.cfg(cfg)
	);

endmodule

// File: source/piarb_cfg_regs.sv
`timescale 1ns/100ps

module piarb_cfg_regs #(
	parameter int buf_nbits = piarb_pkg::BUF_NBITS
) (
	input logic clk,
	input logic rst_n,
	input piarb_pkg::reg_bus_t reg_bus,
	output logic [15:0] reg_rdata,
	input piarb_pkg::depth_t depth,
	input logic inc_rd,
	input logic inc_wr,
	output piarb_pkg::cfg_t cfg
);
	import piarb_pkg::*;

	// Reset limit is the full pointer range
	localparam logic [buf_nbits:0] limit_max = {1'b1, {buf_nbits{1'b0}}};

	logic enable_r;
	logic [buf_nbits:0] limit_r;
	logic [15:0] wr_cnt; // Saturating
	logic [15:0] rd_cnt; // Saturating
	logic [15:0] rd_mux;

	// ====================
	// Register writes
	// ====================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			enable_r <= 1'b0;
			limit_r <= limit_max;
			wr_cnt <= '0;
			rd_cnt <= '0;
		end else begin
			if (reg_bus.wr && reg_bus.addr == reg_ctrl) enable_r <= reg_bus.wdata[0];
			if (reg_bus.wr && reg_bus.addr == reg_limit) limit_r <= reg_bus.wdata[buf_nbits:0];
			// A write to a counter clears it
			if (reg_bus.wr && reg_bus.addr == reg_wr_cnt) wr_cnt <= '0;
			else if (inc_wr && wr_cnt != '1) wr_cnt <= wr_cnt + 1'b1;
			if (reg_bus.wr && reg_bus.addr == reg_rd_cnt) rd_cnt <= '0;
			else if (inc_rd && rd_cnt != '1) rd_cnt <= rd_cnt + 1'b1;
		end
	end

	// Read mux, depth sits in the upper byte of the limit register
	always_comb begin
		case (reg_bus.addr)
			reg_ctrl: rd_mux = {15'd0, enable_r};
			reg_limit: rd_mux = {8'(depth), 8'(limit_r)};
			reg_wr_cnt: rd_mux = wr_cnt;
			default: rd_mux = rd_cnt;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reg_bus.rd) reg_rdata <= rd_mux; // Valid one cycle after the read
	end

	assign cfg = '{enable: enable_r, limit: limit_r};

endmodule

// File: source/piarb_queue_ctrl.sv
`timescale 1ns/100ps

module piarb_queue_ctrl #(
	parameter int buf_nbits = piarb_pkg::BUF_NBITS
) (
	input logic clk,
	input logic rst_n,
	// Enqueue client
	input logic enq_req,
	input piarb_pkg::buf_ptr_t enq_ptr,
	output logic enq_ack,
	// Dequeue client
	input logic deq_req,
	output logic deq_ack,
	output piarb_pkg::buf_ptr_t deq_ptr,
	// Settings from the register block
	input piarb_pkg::cfg_t cfg,
	// Linked list
	output piarb_pkg::ll_req_t ll_req,
	input piarb_pkg::ll_rsp_t ll_rsp,
	output piarb_pkg::depth_t depth
);
	import piarb_pkg::*;

	q_state_t state;
	logic [buf_nbits-1:0] head; // Oldest pointer
	logic [buf_nbits-1:0] tail; // Newest pointer
	logic [buf_nbits:0] count; // Entries in the chain
	logic q_empty;
	logic enq_go; // Enqueue accepted this cycle
	logic deq_go; // Dequeue lookup issued this cycle

	// ====================
	// Request decode
	// ====================
	assign q_empty = (count == '0);

	// Enqueue wins when it can proceed, back-pressure keeps it in idle
	assign enq_go = (state == st_idle) && enq_req && cfg.enable && (count < cfg.limit);
	assign deq_go = (state == st_idle) && deq_req && !q_empty && !enq_go;

	always_comb begin
		ll_req.enq_valid = enq_go && !q_empty; // No link into an empty chain
		ll_req.enq_cur = tail;
		ll_req.enq_nxt = enq_ptr;
		ll_req.look_req = deq_go;
		ll_req.look_ptr = head; // Successor of head becomes new head
	end

	assign depth = count;

	// ====================
	// State machine
	// ====================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
			enq_ack <= 1'b0;
			deq_ack <= 1'b0;
			count <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (enq_go) begin
						state <= st_enq_link;
					end else if (deq_go) begin
						state <= st_deq_look;
					end
				end
				st_enq_link: begin
					count <= count + 1'b1; // Entry counts once linked
					state <= st_enq_ack;
				end
				st_enq_ack: begin
					if (!enq_ack) begin
						enq_ack <= 1'b1; // Third cycle after the request
					end else if (!enq_req) begin
						enq_ack <= 1'b0;
						state <= st_idle;
					end
				end
				st_deq_look: begin
					// Lookup returns three cycles after look_req
					if (ll_rsp.ack_valid) begin
						deq_ack <= 1'b1;
						state <= st_deq_ack;
					end
				end
				st_deq_ack: begin
					if (!deq_req) begin
						deq_ack <= 1'b0;
						count <= count - 1'b1; // Entry leaves at handshake end
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Head, tail and returned pointer
	always_ff @(posedge clk) begin
		if (state == st_enq_link) begin
			tail <= enq_ptr;
			if (q_empty) begin
				head <= enq_ptr; // First entry is both ends
			end
		end
		if (state == st_deq_look && ll_rsp.ack_valid) begin
			deq_ptr <= head; // Old head goes out
			head <= ll_rsp.ack_ptr;
		end
	end

endmodule

// File: source/piarb_linked_list.sv
`timescale 1ns/100ps

module piarb_linked_list #(
	parameter int buf_nbits = piarb_pkg::BUF_NBITS
) (
	input logic clk,
	input logic rst_n,
	input piarb_pkg::ll_req_t ll_req,
	output piarb_pkg::ll_rsp_t ll_rsp
);
	import piarb_pkg::*;

	// Write side, one input stage
	logic enq_valid_d1;
	logic [buf_nbits-1:0] enq_cur_d1; // Link address
	logic [buf_nbits-1:0] enq_nxt_d1; // Link data

	// Lookup side
	logic look_d1;
	logic look_d2; // Lines up with RAM output register
	logic [buf_nbits-1:0] look_ptr_d1;
	logic [buf_nbits-1:0] nxt_ptr; // RAM read data

	// Response registers
	logic ack_valid_r;
	logic [buf_nbits-1:0] ack_ptr_r;

	// ====================
	// Input stage
	// ====================
	always_ff @(posedge clk) begin
		enq_cur_d1 <= ll_req.enq_cur;
		enq_nxt_d1 <= ll_req.enq_nxt;
		look_ptr_d1 <= ll_req.look_ptr;
		ack_ptr_r <= nxt_ptr; // Third stage for the pointer
	end

	// Valid pipeline, three stages for lookups
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			enq_valid_d1 <= 1'b0;
			look_d1 <= 1'b0;
			look_d2 <= 1'b0;
			ack_valid_r <= 1'b0;
		end else begin
			enq_valid_d1 <= ll_req.enq_valid;
			look_d1 <= ll_req.look_req;
			look_d2 <= look_d1;
			ack_valid_r <= look_d2;
		end
	end

	// ====================
	// Next-pointer memory
	// ====================
	ram_1r1w #(
		.data_w(buf_nbits),
		.addr_w(buf_nbits)
	) u_ram_1r1w (
		.clk(clk),
		.wr(enq_valid_d1),
		.waddr(enq_cur_d1),
		.raddr(look_ptr_d1),
		.din(enq_nxt_d1),
		.dout(nxt_ptr)
	);

	always_comb begin
		ll_rsp.ack_valid = ack_valid_r;
		ll_rsp.ack_ptr = ack_ptr_r;
		ll_rsp.inc_rd = look_d1; // Event counters see the first stage
		ll_rsp.inc_wr = enq_valid_d1;
	end

endmodule

// File: source/ram_1r1w.sv
`timescale 1ns/100ps

module ram_1r1w #(
	parameter int data_w = 8,
	parameter int addr_w = 6
) (
	input logic clk,
	input logic wr,
	input logic [addr_w-1:0] waddr,
	input logic [addr_w-1:0] raddr,
	input logic [data_w-1:0] din,
	output logic [data_w-1:0] dout
);

	// ====================
	// Storage
	// ====================
	logic [data_w-1:0] mem [2**addr_w];

	// Write port
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din;
		end
	end

	// Registered read, old data on a same-address collision
	always_ff @(posedge clk) begin
		dout <= mem[raddr];
	end

endmodule

// File: source/piarb_pkg.sv
package piarb_pkg;

	// Default pointer width, the top level passes it down as buf_nbits
	localparam int BUF_NBITS = 6;

	typedef logic [BUF_NBITS-1:0] buf_ptr_t; // Buffer pointer
	typedef logic [BUF_NBITS:0] depth_t; // Occupancy, holds 0 up to the full pointer range

	// Controller states, prefixed so they never collide with the ack ports
	typedef enum logic [2:0] {
		st_idle, // Waiting for a request
		st_enq_link, // Link write in flight, head and tail update
		st_enq_ack, // Enqueue handshake
		st_deq_look, // Waiting for the next-pointer lookup
		st_deq_ack // Dequeue handshake
	} q_state_t;

	typedef enum logic [1:0] {
		reg_ctrl = 2'd0, // Bit 0 enables the queue
		reg_limit = 2'd1, // Depth limit low byte, current depth high byte
		reg_wr_cnt = 2'd2, // Linked-list writes
		reg_rd_cnt = 2'd3 // Linked-list lookups
	} reg_addr_t;

	// Controller to linked list
	typedef struct packed {
		logic enq_valid;
		buf_ptr_t enq_cur; // Current tail
		buf_ptr_t enq_nxt; // Pointer linked behind it
		logic look_req;
		buf_ptr_t look_ptr;
	} ll_req_t;

	// Linked list to controller and register block
	typedef struct packed {
		logic ack_valid;
		buf_ptr_t ack_ptr; // Successor of look_ptr
		logic inc_rd;
		logic inc_wr;
	} ll_rsp_t;

	typedef struct packed {
		logic enable;
		depth_t limit;
	} cfg_t;

	typedef struct packed {
		logic wr;
		logic rd;
		reg_addr_t addr;
		logic [15:0] wdata;
	} reg_bus_t;

endpackage
